// ==== verilog.f ====
+incdir+source
source/periph_pkg.sv
source/regmap_pkg.sv
source/periph_bus_if.sv
source/ms_counter.sv
source/mailbox_regs.sv
source/timer_unit.sv
source/periph_decode.sv
source/mcu_periph_top.sv
tests/tb_mcu_periph.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mcu_periph
FILELIST = verilog.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_mcu_periph.sv ====
/*
 * Testbench for the peripheral register block
 * Random CPU and host traffic against a mailbox model,
 * timer counts and compare interrupt against cycle-exact predictions
 */
`timescale 1ns/1ns
`default_nettype none

`include "periph_config.svh"

module tb_mcu_periph;
	import periph_pkg::*;
	import regmap_pkg::*;

	localparam int N_MBOX_OPS = 40;
	localparam int N_HOST_OPS = 24;
	localparam int IRQ_WAIT_MAX = 64;

	// Test lengths in cycles, worst case
	localparam int MBOX_CYCLES = N_MBOX_OPS * 2 + `MAILBOX_COUNT * 2 + 4;
	localparam int HOST_CYCLES = N_HOST_OPS * 8 + `MAILBOX_COUNT * 3 + 4;
	localparam int COUNT_CYCLES = 8 * 2 + 64 + 4;
	localparam int IRQ_CYCLES = 7 * 2 + IRQ_WAIT_MAX;
	localparam int TEST_CYCLES = 8 + MBOX_CYCLES + HOST_CYCLES + COUNT_CYCLES + 2 * IRQ_CYCLES;

	logic clk_sys;
	logic reset_n;
	logic bus_valid;
	logic bus_wr;
	word_t bus_addr;
	word_t bus_wdata;
	word_t bus_rdata;
	logic bus_rsp_ready;
	logic bridge_wr;
	logic bridge_rd;
	word_t bridge_addr;
	word_t bridge_wr_data;
	word_t bridge_rd_data;
	logic timer_irq;

	int unsigned seed = 12576;
	int unsigned cycle = 0; // Edge number, read right after each rising edge
	int err_count = 0;
	int test_count = 0;
	word_t mbox_model [`MAILBOX_COUNT];

	mcu_periph_top u_dut (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.bus_valid(bus_valid),
		.bus_wr(bus_wr),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.bus_rsp_ready(bus_rsp_ready),
		.bridge_wr(bridge_wr),
		.bridge_rd(bridge_rd),
		.bridge_addr(bridge_addr),
		.bridge_wr_data(bridge_wr_data),
		.bridge_rd_data(bridge_rd_data),
		.timer_irq(timer_irq)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
	end

	function automatic int unsigned next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 15); // Fold high bits into the weak low ones
	endfunction

	function automatic word_t cpu_addr(input offset_t off);
		return {`PERIPH_WINDOW, off};
	endfunction

	function automatic word_t mbox_addr(input mbox_idx_t idx);
		return cpu_addr({3'b000, idx, 2'b00});
	endfunction

	function automatic word_t host_addr(input mbox_idx_t idx);
		return {`HOST_WINDOW, 3'b000, idx, 2'b00};
	endfunction

	// Millisecond count after n edges past the clear edge
	function automatic word_t ms_after(input int unsigned n, input word_t presc);
		return word_t'(n / (presc + 1));
	endfunction

	// Edge after which timer_irq goes high, mask already set
	function automatic int unsigned irq_edge(input int unsigned clr_drive,
			input int unsigned cmp_drive, input word_t cmp, input word_t presc);
		int unsigned clr_edge;
		int unsigned j;
		clr_edge = clr_drive + 1;
		j = cmp + 1; // Tick j sees ms count j-1
		while (clr_edge + j * (presc + 1) <= cmp_drive + 1) begin
			j++;
		end
		return clr_edge + j * (presc + 1) + 1; // Pending one edge after raw
	endfunction

	function automatic timer_status_t status_of(input logic raw, input logic pending,
			input logic enabled);
		timer_status_t s;
		s.irq_raw = raw;
		s.irq_pending = pending;
		s.irq_enabled = enabled;
		return s;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_status(input string name, input timer_status_t exp,
			input timer_status_t act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
			err_count++;
		end
	endtask

	// One access, response sampled one cycle after the strobe
	task automatic cpu_access(input string name, input logic wr, input word_t addr,
			input word_t wdata, output word_t rdata, output int unsigned drive_cycle);
		@(posedge clk_sys);
		drive_cycle = cycle;
		bus_valid <= 1'b1;
		bus_wr <= wr;
		bus_addr <= addr;
		bus_wdata <= wdata;
		@(posedge clk_sys);
		bus_valid <= 1'b0;
		@(negedge clk_sys);
		if (bus_rsp_ready !== 1'b1) begin
			$display("%s: bus response missing one cycle after access to %h", name, addr);
			err_count++;
		end
		rdata = bus_rdata;
	endtask

	task automatic cpu_write(input string name, input word_t addr, input word_t data,
			output int unsigned drive_cycle);
		word_t rdata;
		cpu_access(name, 1'b1, addr, data, rdata, drive_cycle);
		check_word(name, '0, rdata); // Writes answer with zero
	endtask

	task automatic cpu_read(input string name, input word_t addr, output word_t rdata,
			output int unsigned drive_cycle);
		cpu_access(name, 1'b0, addr, '0, rdata, drive_cycle);
	endtask

	task automatic host_write(input mbox_idx_t idx, input word_t data);
		@(posedge clk_sys);
		bridge_wr <= 1'b1;
		bridge_addr <= host_addr(idx);
		bridge_wr_data <= data;
		@(posedge clk_sys);
		bridge_wr <= 1'b0;
	endtask

	// Data lands two cycles after the read strobe
	task automatic host_read(input string name, input mbox_idx_t idx, input word_t exp);
		@(posedge clk_sys);
		bridge_rd <= 1'b1;
		bridge_addr <= host_addr(idx);
		@(posedge clk_sys);
		bridge_rd <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_word(name, exp, bridge_rd_data);
	endtask

	task automatic read_status(input string name, input timer_status_t exp);
		word_t rdata;
		int unsigned dc;
		cpu_read(name, cpu_addr(IRQ_CTRL), rdata, dc);
		check_status(name, exp, timer_status_t'(rdata[STATUS_W-1:0]));
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("%-16s passed", name);
		end else begin
			$display("%-16s failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic test_cpu_mailbox();
		int errs_before;
		int unsigned pick;
		int unsigned dc;
		mbox_idx_t idx;
		logic wr;
		word_t addr;
		word_t data;
		word_t exp;
		word_t rdata;
		errs_before = err_count;
		for (int i = 0; i < N_MBOX_OPS; i++) begin
			pick = next_rand();
			idx = mbox_idx_t'(pick >> 4);
			wr = pick[8];
			data = next_rand();
			exp = '0;
			case ((pick >> 12) % 4)
				0: addr = {24'h00A5C3, 3'b000, idx, 2'b00}; // Outside the window
				1: addr = cpu_addr({3'b010, idx, 2'b00});   // Unmapped offset
				default: begin
					addr = mbox_addr(idx);
					if (wr) begin
						mbox_model[idx] = data;
					end else begin
						exp = mbox_model[idx];
					end
				end
			endcase
			cpu_access("cpu_mailbox", wr, addr, data, rdata, dc);
			check_word("cpu_mailbox", exp, rdata);
		end
		for (int i = 0; i < `MAILBOX_COUNT; i++) begin
			cpu_read("cpu_mailbox", mbox_addr(mbox_idx_t'(i)), rdata, dc);
			check_word("cpu_mailbox", mbox_model[i], rdata);
		end
		report_test("cpu_mailbox", errs_before);
	endtask

	task automatic test_host_bridge();
		int errs_before;
		int unsigned pick;
		int unsigned dc;
		mbox_idx_t idx;
		word_t data;
		word_t rdata;
		errs_before = err_count;
		for (int i = 0; i < N_HOST_OPS; i++) begin
			pick = next_rand();
			idx = mbox_idx_t'(pick >> 4);
			data = next_rand();
			case ((pick >> 10) % 4)
				0: begin
					host_write(idx, data);
					mbox_model[idx] = data;
				end
				1: host_read("host_read", idx, mbox_model[idx]);
				2: begin
					cpu_write("host_bridge", mbox_addr(idx), data, dc);
					mbox_model[idx] = data;
					host_read("host_read", idx, data);
				end
				default: begin
					// Host and CPU hit the same mailbox on one edge
					@(posedge clk_sys);
					bridge_wr <= 1'b1;
					bridge_addr <= host_addr(idx);
					bridge_wr_data <= data;
					bus_valid <= 1'b1;
					bus_wr <= 1'b1;
					bus_addr <= mbox_addr(idx);
					bus_wdata <= ~data;
					@(posedge clk_sys);
					bridge_wr <= 1'b0;
					bus_valid <= 1'b0;
					mbox_model[idx] = data;
					cpu_read("host_collision", mbox_addr(idx), rdata, dc);
					check_word("host_collision", data, rdata);
					host_read("host_collision", idx, data);
				end
			endcase
		end
		for (int i = 0; i < `MAILBOX_COUNT; i++) begin
			host_read("host_read", mbox_idx_t'(i), mbox_model[i]);
		end
		report_test("host_bridge", errs_before);
	endtask

	task automatic test_timer_counts();
		int errs_before;
		int unsigned dc;
		int unsigned clr_1;
		int unsigned clr_2;
		int unsigned dr;
		word_t presc_val;
		word_t rdata;
		errs_before = err_count;
		presc_val = 2 + next_rand() % 6;
		cpu_write("timer_counts", cpu_addr(PRESCALE), presc_val, dc);
		cpu_write("timer_counts", cpu_addr(T1_COUNT), 32'd1, clr_1);
		cpu_write("timer_counts", cpu_addr(T2_COUNT), 32'd1, clr_2);
		repeat (next_rand() % 64) @(posedge clk_sys);
		cpu_read("prescale", cpu_addr(PRESCALE), rdata, dr);
		check_word("prescale", presc_val, rdata);
		cpu_read("t1_count", cpu_addr(T1_COUNT), rdata, dr);
		check_word("t1_count", ms_after(dr - clr_1 - 1, presc_val), rdata);
		cpu_read("t2_count", cpu_addr(T2_COUNT), rdata, dr);
		check_word("t2_count", ms_after(dr - clr_2 - 1, presc_val), rdata);
		cpu_read("t1_cycles", cpu_addr(T1_CYCLES), rdata, dr);
		check_word("t1_cycles", word_t'(dr - clr_1 - 1), rdata);
		cpu_read("t2_cycles", cpu_addr(T2_CYCLES), rdata, dr);
		check_word("t2_cycles", word_t'(dr - clr_2 - 1), rdata);
		report_test("timer_counts", errs_before);
	endtask

	task automatic test_irq_mask_set();
		int errs_before;
		int unsigned dc;
		int unsigned clr;
		int unsigned dcmp;
		int unsigned due;
		int unsigned seen;
		word_t presc_val;
		word_t cmp;
		errs_before = err_count;
		presc_val = 2 + next_rand() % 4;
		cmp = 2 + next_rand() % 3;
		cpu_write("irq_mask_set", cpu_addr(PRESCALE), presc_val, dc);
		cpu_write("irq_mask_set", cpu_addr(IRQ_CTRL), 32'd1, dc);
		cpu_write("irq_mask_set", cpu_addr(T1_COUNT), 32'd1, clr);
		cpu_write("irq_mask_set", cpu_addr(T1_COMPARE), cmp, dcmp);
		due = irq_edge(clr, dcmp, cmp, presc_val);
		seen = 0;
		for (int i = 0; i < IRQ_WAIT_MAX && seen == 0; i++) begin
			@(posedge clk_sys);
			dc = cycle;
			@(negedge clk_sys);
			if (timer_irq === 1'b1) begin
				seen = dc;
			end
		end
		if (seen == 0) begin
			$display("irq_mask_set: timer_irq never rose within %0d cycles", IRQ_WAIT_MAX);
			err_count++;
		end else begin
			check_word("irq_rise_cycle", word_t'(due), word_t'(seen));
		end
		read_status("irq_status_on", status_of(1'b1, 1'b1, 1'b1));
		cpu_write("irq_mask_set", cpu_addr(T1_COUNT), 32'd1, dc);
		read_status("irq_status_off", status_of(1'b0, 1'b0, 1'b0));
		check_flag("irq_after_clear", 1'b0, timer_irq);
		report_test("irq_mask_set", errs_before);
	endtask

	task automatic test_irq_mask_clear();
		int errs_before;
		int unsigned dc;
		int unsigned clr;
		int unsigned dcmp;
		int unsigned due;
		word_t presc_val;
		word_t cmp;
		errs_before = err_count;
		presc_val = 2 + next_rand() % 4;
		cmp = 2 + next_rand() % 3;
		cpu_write("irq_mask_clear", cpu_addr(PRESCALE), presc_val, dc);
		cpu_write("irq_mask_clear", cpu_addr(IRQ_CTRL), 32'd0, dc);
		cpu_write("irq_mask_clear", cpu_addr(T1_COUNT), 32'd1, clr);
		cpu_write("irq_mask_clear", cpu_addr(T1_COMPARE), cmp, dcmp);
		due = irq_edge(clr, dcmp, cmp, presc_val);
		dc = 0;
		while (dc < due) begin
			@(posedge clk_sys);
			dc = cycle;
			@(negedge clk_sys);
			check_flag("irq_masked", 1'b0, timer_irq);
		end
		read_status("irq_status_masked", status_of(1'b1, 1'b1, 1'b1));
		check_flag("irq_masked", 1'b0, timer_irq);
		cpu_write("irq_mask_clear", cpu_addr(IRQ_CTRL), 32'd1, dc);
		check_flag("irq_unmasked", 1'b1, timer_irq);
		report_test("irq_mask_clear", errs_before);
	endtask

	initial begin : watchdog
		repeat (TEST_CYCLES * 2) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES * 2);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		reset_n = 1'b0;
		bus_valid = 1'b0;
		bus_wr = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bridge_wr = 1'b0;
		bridge_rd = 1'b0;
		bridge_addr = '0;
		bridge_wr_data = '0;
		for (int i = 0; i < `MAILBOX_COUNT; i++) begin
			mbox_model[i] = '0;
		end
		repeat (8) @(posedge clk_sys);
		reset_n <= 1'b1;

		test_cpu_mailbox();
		test_host_bridge();
		test_timer_counts();
		test_irq_mask_set();
		test_irq_mask_clear();

		$display("%0d tests run, %0d errors", test_count, err_count);
		if (err_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/mcu_periph_top.sv ====
/*
 * Peripheral register block of the soft-CPU controller
 * Decoder, mailbox and timer parts on one internal bus
 */
`default_nettype none
`timescale 1ns/1ns

module mcu_periph_top (
	input wire clk_sys,
	input wire reset_n,
	input wire bus_valid,
	input wire bus_wr,
	input wire periph_pkg::word_t bus_addr,
	input wire periph_pkg::word_t bus_wdata,
	output periph_pkg::word_t bus_rdata,
	output logic bus_rsp_ready,
	input wire bridge_wr,
	input wire bridge_rd,
	input wire periph_pkg::word_t bridge_addr,
	input wire periph_pkg::word_t bridge_wr_data,
	output periph_pkg::word_t bridge_rd_data,
	output logic timer_irq
);
	import periph_pkg::*;

	word_t mbox_rdata;
	word_t timer_rdata;

	periph_bus_if bus_if ();

	periph_decode u_decode (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.bus_valid(bus_valid),
		.bus_wr(bus_wr),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus(bus_if.decoder),
		.mbox_rdata(mbox_rdata),
		.timer_rdata(timer_rdata),
		.bus_rdata(bus_rdata),
		.bus_rsp_ready(bus_rsp_ready)
	);

	mailbox_regs u_mailbox (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.bus(bus_if.target),
		.bridge_wr(bridge_wr),
		.bridge_rd(bridge_rd),
		.bridge_addr(bridge_addr),
		.bridge_wr_data(bridge_wr_data),
		.bridge_rd_data(bridge_rd_data),
		.mbox_rdata(mbox_rdata)
	);

	timer_unit u_timer (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.bus(bus_if.target),
		.timer_rdata(timer_rdata),
		.timer_irq(timer_irq)
	);

endmodule

`default_nettype wire

// ==== source/periph_decode.sv ====
/*
 * CPU window decode, register bus strobes
 * and the one-cycle bus response with combined read data
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_config.svh"

module periph_decode (
	input wire clk_sys,
	input wire reset_n,
	input wire bus_valid,
	input wire bus_wr,
	input wire periph_pkg::word_t bus_addr,
	input wire periph_pkg::word_t bus_wdata,
	periph_bus_if.decoder bus,
	input wire periph_pkg::word_t mbox_rdata,
	input wire periph_pkg::word_t timer_rdata,
	output periph_pkg::word_t bus_rdata,
	output logic bus_rsp_ready
);
	logic in_window;
	logic read_hit; // Last access was an in-window read

	assign in_window = bus_addr[`PERIPH_DATA_W-1:8] == `PERIPH_WINDOW;

	assign bus.wr_en = bus_valid && bus_wr && in_window;
	assign bus.rd_en = bus_valid && !bus_wr && in_window;
	assign bus.offset = bus_addr[7:0];
	assign bus.wdata = bus_wdata;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			bus_rsp_ready <= 1'b0;
			read_hit <= 1'b0;
		end else begin
			bus_rsp_ready <= bus_valid; // Every access answers, mapped or not
			read_hit <= bus.rd_en;
		end
	end

	// Each part returns zero for offsets it does not own
	assign bus_rdata = read_hit ? (mbox_rdata | timer_rdata) : '0;

	// The OR never merges two answering parts
	read_words_disjoint: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(mbox_rdata & timer_rdata) == '0);

endmodule

`default_nettype wire

// ==== source/timer_unit.sv ====
/*
 * Timer registers, two millisecond counters
 * and the timer 1 compare interrupt with enable and mask
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_config.svh"

module timer_unit (
	input wire clk_sys,
	input wire reset_n,
	periph_bus_if.target bus,
	output periph_pkg::word_t timer_rdata,
	output logic timer_irq
);
	import periph_pkg::*;
	import regmap_pkg::*;

	word_t prescale;
	word_t compare;
	word_t ms_1;
	word_t ms_2;
	word_t cycles_1;
	word_t cycles_2;
	word_t rd_word;
	logic clear_1;
	logic clear_2;
	logic tick_1;
	logic irq_enabled;
	logic irq_mask;
	logic irq_raw;
	logic irq_pending;
	timer_status_t status;

	assign clear_1 = bus.wr_en && bus.offset == T1_COUNT && bus.wdata[CLEAR_BIT];
	assign clear_2 = bus.wr_en && bus.offset == T2_COUNT && bus.wdata[CLEAR_BIT];

	ms_counter u_timer_1 (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.clear(clear_1),
		.prescale(prescale),
		.tick(tick_1),
		.ms_count(ms_1),
		.cycle_count(cycles_1)
	);

	ms_counter u_timer_2 (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.clear(clear_2),
		.prescale(prescale),
		.tick(), // No compare on timer 2
		.ms_count(ms_2),
		.cycle_count(cycles_2)
	);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			prescale <= `PRESCALE_RESET;
			compare <= '0;
			irq_enabled <= 1'b0;
			irq_mask <= 1'b0;
			irq_raw <= 1'b0;
			irq_pending <= 1'b0;
		end else begin
			if (bus.wr_en) begin
				case (bus.offset)
					PRESCALE: prescale <= bus.wdata;
					T1_COUNT: irq_enabled <= 1'b0;
					T1_COMPARE: begin
						compare <= bus.wdata;
						irq_enabled <= 1'b1; // Arming the compare enables it
					end
					IRQ_CTRL: irq_mask <= bus.wdata[MASK_BIT];
					default: ;
				endcase
			end
			// Sticky until timer 1 is cleared
			if (clear_1) begin
				irq_raw <= 1'b0;
			end else if (tick_1 && compare != '0 && ms_1 >= compare) begin
				irq_raw <= 1'b1;
			end
			irq_pending <= irq_enabled && irq_raw;
		end
	end

	assign timer_irq = irq_pending && irq_mask;

	assign status.irq_raw = irq_raw;
	assign status.irq_pending = irq_pending;
	assign status.irq_enabled = irq_enabled;

	always_comb begin
		rd_word = '0;
		case (bus.offset)
			PRESCALE: rd_word = prescale;
			T1_COUNT: rd_word = ms_1;
			T1_COMPARE: rd_word = compare;
			T2_COUNT: rd_word = ms_2;
			IRQ_CTRL: rd_word = {{(`PERIPH_DATA_W - STATUS_W){1'b0}}, status};
			T1_CYCLES: rd_word = cycles_1;
			T2_CYCLES: rd_word = cycles_2;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			timer_rdata <= '0;
		end else begin
			timer_rdata <= bus.rd_en ? rd_word : '0;
		end
	end

	// Raw only rises once timer 1 has counted past the compare value
	raw_after_compare: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(irq_raw) |-> ms_1 > $past(compare));

endmodule

`default_nettype wire

// ==== source/mailbox_regs.sv ====
/*
 * Eight shared mailbox registers
 * Host bridge writes win over CPU writes to the same word,
 * two-stage host read path and a registered CPU read word
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_config.svh"

module mailbox_regs (
	input wire clk_sys,
	input wire reset_n,
	periph_bus_if.target bus,
	input wire bridge_wr,
	input wire bridge_rd,
	input wire periph_pkg::word_t bridge_addr,
	input wire periph_pkg::word_t bridge_wr_data,
	output periph_pkg::word_t bridge_rd_data,
	output periph_pkg::word_t mbox_rdata
);
	import periph_pkg::*;
	import regmap_pkg::*;

	word_t mbox [`MAILBOX_COUNT];
	word_t host_stage;
	mbox_idx_t host_idx;
	mbox_idx_t cpu_idx;
	logic host_wr_hit;
	logic cpu_wr_hit;
	logic cpu_own;

	assign host_idx = bridge_addr[4:2];
	assign cpu_idx = bus.offset[4:2];

	// Word aligned and inside the mailbox range
	assign cpu_own = bus.offset <= MBOX_7 && bus.offset[1:0] == 2'b00;
	assign cpu_wr_hit = bus.wr_en && cpu_own;
	assign host_wr_hit = bridge_wr && bridge_addr[31:8] == `HOST_WINDOW
		&& bridge_addr[7:0] <= MBOX_7 && bridge_addr[1:0] == 2'b00;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < `MAILBOX_COUNT; i++) begin
				mbox[i] <= '0;
			end
			mbox_rdata <= '0;
		end else begin
			for (int i = 0; i < `MAILBOX_COUNT; i++) begin
				if (host_wr_hit && host_idx == mbox_idx_t'(i)) begin
					mbox[i] <= bridge_wr_data; // Host has priority
				end else if (cpu_wr_hit && cpu_idx == mbox_idx_t'(i)) begin
					mbox[i] <= bus.wdata;
				end
			end
			mbox_rdata <= (bus.rd_en && cpu_own) ? mbox[cpu_idx] : '0;
		end
	end

	// Host read, two stages to the bridge
	always_ff @(posedge clk_sys) begin
		if (bridge_rd) begin
			host_stage <= mbox[host_idx];
		end
		bridge_rd_data <= host_stage; // Holds between reads
	end

	// Bridge traffic outside its window is never also unaligned
	host_addr_sane: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(bridge_wr || bridge_rd) |->
			(bridge_addr[31:8] == `HOST_WINDOW || bridge_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== source/ms_counter.sv ====
/*
 * Prescaled millisecond counter with a free cycle count
 * and a synchronous clear
 */
`default_nettype none
`timescale 1ns/1ns

module ms_counter (
	input wire clk_sys,
	input wire reset_n,
	input wire clear,
	input wire periph_pkg::word_t prescale,
	output logic tick,
	output periph_pkg::word_t ms_count,
	output periph_pkg::word_t cycle_count
);
	import periph_pkg::*;

	word_t presc_count;

	// Millisecond boundary, PRESCALE+1 cycles apart
	assign tick = !clear && presc_count == prescale;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			presc_count <= '0;
			ms_count <= '0;
			cycle_count <= '0;
		end else if (clear) begin
			presc_count <= '0;
			ms_count <= '0;
			cycle_count <= '0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
			if (tick) begin
				presc_count <= '0;
				ms_count <= ms_count + 1'b1;
			end else begin
				presc_count <= presc_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/periph_bus_if.sv ====
/*
 * Internal register bus from the window decoder
 * to the mailbox and timer register parts
 */
`default_nettype none
`timescale 1ns/1ns

interface periph_bus_if;
	import periph_pkg::*;

	logic    wr_en;  // One-cycle strobes, already window checked
	logic    rd_en;
	offset_t offset;
	word_t   wdata;

	modport decoder (output wr_en, rd_en, offset, wdata);
	modport target (input wr_en, rd_en, offset, wdata);

endinterface

`default_nettype wire

// ==== source/regmap_pkg.sv ====
/*
 * CPU register map of the peripheral window
 * Offsets and the bit layout of control and status words
 */
`default_nettype none

package regmap_pkg;

	typedef enum periph_pkg::offset_t {
		MBOX_0     = 8'h00,
		MBOX_1     = 8'h04,
		MBOX_2     = 8'h08,
		MBOX_3     = 8'h0C,
		MBOX_4     = 8'h10,
		MBOX_5     = 8'h14,
		MBOX_6     = 8'h18,
		MBOX_7     = 8'h1C,
		PRESCALE   = 8'h98,
		T1_COUNT   = 8'hC4, // Any write disables the compare irq
		T1_COMPARE = 8'hC8,
		T2_COUNT   = 8'hCC,
		IRQ_CTRL   = 8'hF4,
		T1_CYCLES  = 8'hF8,
		T2_CYCLES  = 8'hFC
	} reg_offset_e;

	localparam int CLEAR_BIT = 0; // In T1_COUNT and T2_COUNT writes
	localparam int MASK_BIT  = 0; // In IRQ_CTRL writes
	localparam int STATUS_W  = $bits(periph_pkg::timer_status_t);

endpackage

`default_nettype wire

// ==== source/periph_pkg.sv ====
/*
 * Data types shared across the peripheral block
 * Bus word, window offset, mailbox index, timer status word
 */
`default_nettype none

`include "periph_config.svh"

package periph_pkg;

	typedef logic [`PERIPH_DATA_W-1:0] word_t;

	// Byte offset inside a 256-byte window
	typedef logic [7:0] offset_t;

	typedef logic [$clog2(`MAILBOX_COUNT)-1:0] mbox_idx_t;

	// Low bits of the IRQ_CTRL read word
	typedef struct packed {
		logic irq_raw;      // Compare reached on timer 1
		logic irq_pending;  // Raw, qualified by enable
		logic irq_enabled;
	} timer_status_t;

endpackage

`default_nettype wire

// ==== source/periph_config.svh ====
/*
 * Build settings for the peripheral register block
 * Bus width, CPU and host address windows, mailbox count
 * and the prescaler value after reset
 */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

`define PERIPH_DATA_W 32 // Data and address width

// Upper 24 address bits of each window
`define PERIPH_WINDOW 24'hFFFFFF
`define HOST_WINDOW 24'hF00000

`define MAILBOX_COUNT 8

// Kept small so a millisecond passes in a handful of cycles
`define PRESCALE_RESET 32'd9

`endif
